// File: tb.f
+incdir+tests
design/rng_pkg.sv
design/lcg_stage.sv
design/noise_mixer.sv
design/frame_packer.sv
design/noise_stream_top.sv
tests/tb_noise_stream.sv

// File: tests/tb_noise_model.svh
// Reference model of the LCG pair, byte mixing and frame counting, included by the noise stream testbench
`ifndef TB_NOISE_MODEL_SVH
`define TB_NOISE_MODEL_SVH

// Model state, restarted at reset and on every reseed
logic [31:0] model_x;
logic [31:0] model_y;
int          model_count;

// x_next = mult * x + incr, kept to the low 32 bits
function automatic logic [31:0] step_lcg(
    input logic [31:0] cur,
    input logic [31:0] mult,
    input logic [31:0] incr
);
    logic [63:0] wide;
    wide = ({32'd0, cur} * {32'd0, mult}) + {32'd0, incr};
    return wide[31:0];
endfunction

// Restart from a seed pair, frame numbering starts again too
task automatic restart_model(input logic [31:0] sx, input logic [31:0] sy);
    model_x     = sx;
    model_y     = sy;
    model_count = 0;
endtask

// Next expected output, sample k comes from the k-th stepped state
task automatic predict_sample(output logic [15:0] data, output logic last);
    logic [15:0] x_top;
    logic [15:0] y_top;
    model_x = step_lcg(model_x, x_mult, x_incr);
    model_y = step_lcg(model_y, y_mult, y_incr);
    x_top   = {8'd0, model_x[31:24]};
    y_top   = {8'd0, model_y[31:24]};
    data    = x_top * y_top;
    model_count = model_count + 1;
    // Frame ends on transfers FRAME_LEN, 2*FRAME_LEN and so on
    last = ((model_count % FRAME_LEN) == 0);
endtask

`endif

// File: tests/tb_noise_stream.sv
// Testbench for the noise stream top that checks back-pressure and reseeds against an LCG model
`timescale 1ns/1ns
`default_nettype none

module tb_noise_stream
    import rng_pkg::*;
;

    localparam int FRAME_LEN     = 16;
    localparam int CLK_PERIOD    = 4;
    localparam int FREE_SAMPLES  = 100;
    localparam int BP_SAMPLES    = 300;
    localparam int SEED_SAMPLES  = 400;
    localparam int TOTAL_SAMPLES = FREE_SAMPLES + BP_SAMPLES + SEED_SAMPLES;

    logic        aclk;
    logic        aresetn;
    logic        seed_load;
    logic [31:0] seed_x;
    logic [31:0] seed_y;
    logic [15:0] m_axis_tdata;
    logic        m_axis_tvalid;
    logic        m_axis_tready;
    logic        m_axis_tlast;

    int checks;
    int errors;
    int accepted;
    int frames;
    int reseeds;
    int drops;

    // Output held back last cycle that must stay unchanged
    logic        hold_pending;
    logic [15:0] hold_data;
    logic        hold_last;
    logic        after_reset;

    `include "tb_noise_model.svh"

    noise_stream_top #(
        .FRAME_LEN (FRAME_LEN)
    ) i_dut (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .seed_load     (seed_load),
        .seed_x        (seed_x),
        .seed_y        (seed_y),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

    initial begin
        aclk = 1'b0;
    end

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic check_value(
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("error at %0t ns: %s expected 0x%0h got 0x%0h",
                     $time, what, expected, actual);
        end
    endtask

    // One reseed pulse with fresh random seeds while the sink is not ready
    task automatic pulse_reseed();
        @(posedge aclk);
        #1;
        seed_load     = 1'b1;
        seed_x        = $urandom;
        seed_y        = $urandom;
        m_axis_tready = 1'b0;
    endtask

    // Random traffic until the accepted count reaches target
    task automatic run_traffic(input int target, input int ready_pct, input int reseed_pm);
        while (accepted < target) begin
            @(posedge aclk);
            #1;
            if (reseed_pm > 0 && ($urandom % 1000) < reseed_pm) begin
                seed_load     = 1'b1;
                seed_x        = $urandom;
                seed_y        = $urandom;
                m_axis_tready = 1'b0;
            end else begin
                seed_load     = 1'b0;
                m_axis_tready = (($urandom % 100) < ready_pct);
            end
        end
    endtask

    // Outputs are sampled mid-cycle and a transfer completes at the next rising edge
    always @(negedge aclk) begin : monitor
        logic [15:0] exp_data;
        logic        exp_last;
        if (!aresetn) begin
            check_value("tvalid in reset", 32'd0, {31'd0, m_axis_tvalid});
            check_value("tlast in reset", 32'd0, {31'd0, m_axis_tlast});
            restart_model(x_seed_default, y_seed_default);
            hold_pending = 1'b0;
            after_reset  = 1'b1;
        end else begin
            if (after_reset) begin
                check_value("tvalid after reset", 32'd0, {31'd0, m_axis_tvalid});
                check_value("tlast after reset", 32'd0, {31'd0, m_axis_tlast});
                after_reset = 1'b0;
            end
            if (hold_pending) begin
                check_value("tvalid held", 32'd1, {31'd0, m_axis_tvalid});
                check_value("tdata held", {16'd0, hold_data}, {16'd0, m_axis_tdata});
                check_value("tlast held", {31'd0, hold_last}, {31'd0, m_axis_tlast});
            end
            if (m_axis_tvalid && m_axis_tready) begin
                predict_sample(exp_data, exp_last);
                check_value("tdata", {16'd0, exp_data}, {16'd0, m_axis_tdata});
                check_value("tlast", {31'd0, exp_last}, {31'd0, m_axis_tlast});
                accepted = accepted + 1;
                if (m_axis_tlast) begin
                    frames = frames + 1;
                end
            end
            // In-flight samples are dropped and the model starts over
            if (seed_load) begin
                restart_model(seed_x, seed_y);
                reseeds = reseeds + 1;
                if (m_axis_tvalid) begin
                    drops = drops + 1;
                end
            end
            hold_pending = m_axis_tvalid && !m_axis_tready && !seed_load;
            hold_data    = m_axis_tdata;
            hold_last    = m_axis_tlast;
        end
    end

    initial begin
        checks        = 0;
        errors        = 0;
        accepted      = 0;
        frames        = 0;
        reseeds       = 0;
        drops         = 0;
        hold_pending  = 1'b0;
        hold_data     = '0;
        hold_last     = 1'b0;
        after_reset   = 1'b0;
        aresetn       = 1'b0;
        seed_load     = 1'b0;
        seed_x        = '0;
        seed_y        = '0;
        m_axis_tready = 1'b0;
        void'($urandom(79884));

        repeat (2) @(posedge aclk);
        #1;
        aresetn       = 1'b1;
        m_axis_tready = 1'b1;

        // Free run from the default seeds
        run_traffic(FREE_SAMPLES, 100, 0);

        // Random back-pressure without reseeds
        run_traffic(FREE_SAMPLES + BP_SAMPLES, 50, 0);

        // Back-pressure with reseeds at random points
        pulse_reseed();
        run_traffic(TOTAL_SAMPLES, 50, 12);

        @(posedge aclk);
        #1;
        seed_load     = 1'b0;
        m_axis_tready = 1'b0;
        repeat (4) @(posedge aclk);

        if (drops == 0) begin
            errors = errors + 1;
            $display("no reseed arrived while an output was pending");
        end
        if (frames == 0) begin
            errors = errors + 1;
            $display("no frame end was seen on the output");
        end

        $display("summary: %0d checks, %0d errors, %0d samples, %0d frames, %0d reseeds, %0d drops",
                 checks, errors, accepted, frames, reseeds, drops);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Generous bound of 40 cycles per planned sample
    initial begin
        #(TOTAL_SAMPLES * 40 * CLK_PERIOD);
        $display("timeout: only %0d of %0d samples were accepted", accepted, TOTAL_SAMPLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : tb_noise_stream

`default_nettype wire

// File: design/noise_stream_top.sv
// Top level of the streaming noise source, joins two LCGs, the mixer and the frame packer
`timescale 1ns/1ns
`default_nettype none

module noise_stream_top
    import rng_pkg::*;
#(
    parameter int FRAME_LEN = 16
) (
    input  wire          aclk,
    input  wire          aresetn,
    input  wire          seed_load,
    input  wire state_t  seed_x,
    input  wire state_t  seed_y,
    output wire sample_t m_axis_tdata,
    output wire          m_axis_tvalid,
    input  wire          m_axis_tready,
    output wire          m_axis_tlast
);

    state_t  x_state;
    state_t  y_state;
    wire     x_valid;
    wire     y_valid;
    wire     src_valid;
    wire     src_ready;
    sample_t mix_data;
    wire     mix_valid;
    wire     mix_ready;

    // Generators step in lockstep, both see the same ready
    lcg_stage #(
        .MULT         (x_mult),
        .INCR         (x_incr),
        .SEED_DEFAULT (x_seed_default)
    ) i_lcg_x (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .seed_load (seed_load),
        .seed      (seed_x),
        .state     (x_state),
        .valid     (x_valid),
        .ready     (src_ready)
    );

    lcg_stage #(
        .MULT         (y_mult),
        .INCR         (y_incr),
        .SEED_DEFAULT (y_seed_default)
    ) i_lcg_y (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .seed_load (seed_load),
        .seed      (seed_y),
        .state     (y_state),
        .valid     (y_valid),
        .ready     (src_ready)
    );

    assign src_valid = x_valid && y_valid;

    // Reseed doubles as the pipeline flush
    noise_mixer i_mixer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .flush     (seed_load),
        .x_state   (x_state),
        .y_state   (y_state),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .mix_data  (mix_data),
        .mix_valid (mix_valid),
        .mix_ready (mix_ready)
    );

    frame_packer #(
        .FRAME_LEN (FRAME_LEN)
    ) i_packer (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .flush         (seed_load),
        .mix_data      (mix_data),
        .mix_valid     (mix_valid),
        .mix_ready     (mix_ready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast)
    );

endmodule : noise_stream_top

`default_nettype wire

// File: design/frame_packer.sv
// AXI-Stream output register that counts transfers and marks every FRAME_LEN-th sample with tlast
`timescale 1ns/1ns
`default_nettype none

module frame_packer
    import rng_pkg::*;
#(
    parameter int FRAME_LEN = 16
) (
    input  wire          aclk,
    input  wire          aresetn,
    input  wire          flush,
    input  wire sample_t mix_data,
    input  wire          mix_valid,
    output logic         mix_ready,
    output sample_t      m_axis_tdata,
    output logic         m_axis_tvalid,
    input  wire          m_axis_tready,
    output logic         m_axis_tlast
);

    // Counter wide enough for FRAME_LEN-1, at least one bit
    localparam int CNT_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_LEN - 1);

    logic [CNT_W-1:0] frame_cnt;
    logic             out_ready;
    logic             take;
    logic             frame_end;

    // Register is free when empty or when the sink takes its sample now
    assign out_ready = !m_axis_tvalid || m_axis_tready;
    assign take      = out_ready && mix_valid;
    assign frame_end = (frame_cnt == CNT_LAST);

    assign mix_ready = out_ready;

    // Control, cleared by reset and by reseed
    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            frame_cnt     <= '0;
        end else if (take) begin
            m_axis_tvalid <= 1'b1;
            m_axis_tlast  <= frame_end;
            if (frame_end) begin
                frame_cnt <= '0;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end else if (m_axis_tready) begin
            // Sample left and nothing new arrived
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge aclk) begin
        if (take) begin
            m_axis_tdata <= mix_data;
        end
    end

endmodule : frame_packer

`default_nettype wire

// File: design/noise_mixer.sv
// Three-stage valid/ready pipeline that turns two LCG states into one 16-bit byte product
`timescale 1ns/1ns
`default_nettype none

module noise_mixer
    import rng_pkg::*;
(
    input  wire         aclk,
    input  wire         aresetn,
    input  wire         flush,
    input  wire state_t x_state,
    input  wire state_t y_state,
    input  wire         src_valid,
    output logic        src_ready,
    output sample_t     mix_data,
    output logic        mix_valid,
    input  wire         mix_ready
);

    // Stage one, upper bytes of both states
    byte_t   s1_x_byte;
    byte_t   s1_y_byte;
    logic    s1_valid;
    logic    s1_ready;

    // Stage two, product of the bytes
    sample_t s2_product;
    logic    s2_valid;
    logic    s2_ready;

    // Stage three, holding register toward the packer
    sample_t s3_data;
    logic    s3_valid;
    logic    s3_ready;

    // A stage takes new data when empty or when its content leaves this cycle
    assign s3_ready = !s3_valid || mix_ready;
    assign s2_ready = !s2_valid || s3_ready;
    assign s1_ready = !s1_valid || s2_ready;

    assign src_ready = s1_ready;

    // Valid bits, cleared by reset and by a reseed flush
    always_ff @(posedge aclk) begin
        if (!aresetn || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= src_valid;
            end
            if (s2_ready) begin
                s2_valid <= s1_valid;
            end
            if (s3_ready) begin
                s3_valid <= s2_valid;
            end
        end
    end

    // Byte extraction
    always_ff @(posedge aclk) begin
        if (s1_ready && src_valid) begin
            s1_x_byte <= x_state[state_w-1 -: byte_w];
            s1_y_byte <= y_state[state_w-1 -: byte_w];
        end
    end

    // 8x8 multiply, full 16-bit result
    always_ff @(posedge aclk) begin
        if (s2_ready && s1_valid) begin
            s2_product <= sample_t'(s1_x_byte) * sample_t'(s1_y_byte);
        end
    end

    // Output register, holds steady while the packer stalls
    always_ff @(posedge aclk) begin
        if (s3_ready && s2_valid) begin
            s3_data <= s2_product;
        end
    end

    assign mix_data  = s3_data;
    assign mix_valid = s3_valid;

endmodule : noise_mixer

`default_nettype wire

// File: design/lcg_stage.sv
// One 32-bit linear congruential generator with valid/ready output and reseed, used twice by the top
`timescale 1ns/1ns
`default_nettype none

module lcg_stage
    import rng_pkg::*;
#(
    parameter state_t MULT         = x_mult,
    parameter state_t INCR         = x_incr,
    parameter state_t SEED_DEFAULT = x_seed_default
) (
    input  wire         aclk,
    input  wire         aresetn,
    input  wire         seed_load,
    input  wire state_t seed,
    output state_t      state,
    output logic        valid,
    input  wire         ready
);

    // One step of the recurrence, wraps modulo 2^32
    function automatic state_t lcg_step(input state_t cur);
        lcg_step = (cur * MULT) + INCR;
    endfunction

    // First stepped value of the default seed, so the register holds sample one's source
    localparam state_t RESET_STATE = (SEED_DEFAULT * MULT) + INCR;

    state_t state_q;
    logic   valid_q;
    logic   advance;

    // The pair moves on only when the consumer takes it
    assign advance = valid_q && ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_q <= RESET_STATE;
        end else if (seed_load) begin
            // Reseed wins over a step in the same cycle
            state_q <= lcg_step(seed);
        end else if (advance) begin
            state_q <= lcg_step(state_q);
        end
    end

    // Valid drops for one cycle after reset or reseed, matching the flushed pipeline
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= !seed_load;
        end
    end

    assign state = state_q;
    assign valid = valid_q;

endmodule : lcg_stage

`default_nettype wire

// File: design/rng_pkg.sv
// Shared widths, types, seeds and LCG constants for the noise source, imported by each design module
`default_nettype none

package rng_pkg;

    // Widths that carry a meaning through the chain
    localparam int state_w  = 32;
    localparam int byte_w   = 8;
    localparam int sample_w = 16;

    // Generator state, one per LCG
    typedef logic [state_w-1:0] state_t;

    // Upper byte of a generator state
    typedef logic [byte_w-1:0] byte_t;

    // One output noise sample, product of two bytes
    typedef logic [sample_w-1:0] sample_t;

    // Generator X recurrence, classic C library constants
    localparam state_t x_mult = 32'd1103515245;
    localparam state_t x_incr = 32'd12345;

    // Generator Y recurrence
    localparam state_t y_mult = 32'd214013;
    localparam state_t y_incr = 32'd2531011;

    // Seeds loaded at reset
    localparam state_t x_seed_default = 32'h12345678;
    localparam state_t y_seed_default = 32'h87654321;

endpackage : rng_pkg

`default_nettype wire
